/* project.f */
ahb_bus_pkg.sv
ahb_master_pkg.sv
ahb_req_check.sv
ahb_burst_addr.sv
ahb_master_fsm.sv
ahb_data_phase.sv
ahb_master_top.sv
tb_ahb_master.sv

/* Makefile */
TOP := tb_ahb_master

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

/* tb_ahb_master.sv */
// Testbench for the AHB-Lite master: slave memory model, stimulus table,
// response monitor, checks and clock.
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_master;

    import ahb_bus_pkg::*;

    localparam int max_rows = 16;

    logic            ahb_clk_in = 1'b0;
    logic            ahb_rstn_in = 1'b0;
    logic [31:0]     ahb_addr;
    ahb_burst_e      ahb_burst;
    ahb_size_t       ahb_size;
    ahb_trans_e      ahb_trans;
    logic            ahb_write;
    logic [31:0]     ahb_wdata;
    logic [31:0]     ahb_rdata = '0;
    logic            ahb_ready = 1'b1;
    logic            ahb_resp = 1'b0;
    logic            req_valid = 1'b0;
    logic            req_write = 1'b0;
    logic            req_delay = 1'b0;
    logic [31:0]     req_addr = '0;
    ahb_burst_e      req_burst = burst_single;
    ahb_size_t       req_size = 3'd2;
    logic [31:0]     req_wdata = '0;
    logic            req_accept;
    logic            busy;
    logic            rsp_valid;
    logic            rsp_error;
    logic [31:0]     rsp_rdata;

    // Stimulus table, one entry per transfer.
    logic [31:0] t_addr [max_rows];
    ahb_burst_e  t_burst [max_rows];
    ahb_size_t   t_size [max_rows];
    logic        t_write [max_rows];
    int          t_seed [max_rows];
    int          t_wait [max_rows];
    int          t_delay [max_rows];
    int          t_errb [max_rows];
    int          t_exp_err [max_rows];
    int          t_exp_acc [max_rows];
    int          t_exp_rsp [max_rows];
    int          n_rows = 0;

    logic [31:0] mem [256];
    logic [31:0] ref_mem [256];
    logic [31:0] row_data [16];
    logic [31:0] lcg_state = 32'd38345;
    logic [31:0] mon_exp;
    logic [31:0] drv_addr;
    int cur = 0;
    logic row_active = 1'b0;
    int acc_cnt;
    int rsp_cnt;
    int err_cnt;
    int ok_cnt;
    int bus_cnt;
    int busy_cnt;
    int fail_cnt = 0;
    int rows_failed = 0;
    int cycle_cnt = 0;
    int cycle_limit = 100000;

    // Slave data-phase state.
    logic        dp_active = 1'b0;
    logic        dp_write;
    logic        dp_err;
    logic [7:0]  dp_idx;
    int          wait_left = 0;
    int          sl_beat = 0;

    ahb_master_top #(
        .addr_width(32),
        .data_width(32),
        .wait_timeout(6)
    ) dut (
        .ahb_clk_in(ahb_clk_in), .ahb_rstn_in(ahb_rstn_in),
        .ahb_addr(ahb_addr), .ahb_burst(ahb_burst), .ahb_size(ahb_size),
        .ahb_trans(ahb_trans), .ahb_write(ahb_write), .ahb_wdata(ahb_wdata),
        .ahb_rdata(ahb_rdata), .ahb_ready(ahb_ready), .ahb_resp(ahb_resp),
        .req_valid(req_valid), .req_write(req_write), .req_delay(req_delay),
        .req_addr(req_addr), .req_burst(req_burst), .req_size(req_size),
        .req_wdata(req_wdata), .req_accept(req_accept), .busy(busy),
        .rsp_valid(rsp_valid), .rsp_error(rsp_error), .rsp_rdata(rsp_rdata)
    );

    initial begin
        forever #10 ahb_clk_in = ~ahb_clk_in;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int beats_of(input ahb_burst_e b);
        case (b)
            burst_wrap4, burst_incr4:   return 4;
            burst_wrap8, burst_incr8:   return 8;
            burst_wrap16, burst_incr16: return 16;
            default:                    return 1;
        endcase
    endfunction

    // Expected address of beat k in row r.
    function automatic logic [31:0] beat_addr(input int r, input int k);
        logic [31:0] base;
        logic [31:0] bytes;
        logic [31:0] region;
        base  = t_addr[r];
        bytes = 32'd1 << t_size[r];
        if (t_burst[r] inside {burst_wrap4, burst_wrap8, burst_wrap16}) begin
            region = 32'(beats_of(t_burst[r])) * bytes;
            return base - (base % region) + ((base % region) + 32'(k) * bytes) % region;
        end
        return base + 32'(k) * bytes;
    endfunction

    task automatic add_row(input logic [31:0] addr, input ahb_burst_e burst,
                           input ahb_size_t size, input logic write, input int seed,
                           input int wt, input int delay, input int errb,
                           input int exp_err, input int exp_acc, input int exp_rsp);
        t_addr[n_rows]    = addr;
        t_burst[n_rows]   = burst;
        t_size[n_rows]    = size;
        t_write[n_rows]   = write;
        t_seed[n_rows]    = seed;
        t_wait[n_rows]    = wt;
        t_delay[n_rows]   = delay;
        t_errb[n_rows]    = errb;
        t_exp_err[n_rows] = exp_err;
        t_exp_acc[n_rows] = exp_acc;
        t_exp_rsp[n_rows] = exp_rsp;
        n_rows++;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
        fail_cnt++;
    endtask

    ////////////////////////////////////////
    // Slave model, registered at the rising edge.
    always @(posedge ahb_clk_in) begin
        if (!ahb_rstn_in || !row_active) begin
            sl_beat = 0;
        end
        if (!ahb_rstn_in) begin
            dp_active = 1'b0;
        end else begin
            if (dp_active && ahb_ready) begin
                if (dp_write && !dp_err) begin
                    mem[dp_idx] = ahb_wdata;
                end
                dp_active = 1'b0;
            end else if (dp_active && wait_left > 0) begin
                wait_left--;
            end
            if (ahb_ready && !ahb_resp && ahb_trans inside {trans_nonseq, trans_seq}) begin
                dp_active = 1'b1;
                dp_idx    = ahb_addr[9:2];
                dp_write  = ahb_write;
                wait_left = t_wait[cur];
                dp_err    = (sl_beat == t_errb[cur]);
                sl_beat++;
            end
        end
    end

    // Slave outputs change on the falling edge.
    always @(negedge ahb_clk_in) begin
        ahb_ready = !dp_active || wait_left == 0;
        ahb_resp  = dp_active && dp_err && wait_left == 0;
        ahb_rdata = (dp_active && !dp_write) ? mem[dp_idx] : '0;
    end

    ////////////////////////////////////////
    // Bus and response monitor.
    always @(posedge ahb_clk_in) begin
        if (!row_active) begin
            acc_cnt  = 0;
            rsp_cnt  = 0;
            err_cnt  = 0;
            ok_cnt   = 0;
            bus_cnt  = 0;
            busy_cnt = 0;
        end else if (ahb_rstn_in) begin
            if (ahb_trans != trans_idle) begin
                bus_cnt++;
            end
            if (err_cnt > 0 && ahb_trans inside {trans_nonseq, trans_seq}) begin
                $display("%0t: transfer issued after an error response", $time);
                fail_cnt++;
            end
            if (ahb_trans == trans_busy) begin
                busy_cnt++;
                if (ahb_addr !== beat_addr(cur, acc_cnt)) begin
                    report_mismatch("ahb_addr", ahb_addr, beat_addr(cur, acc_cnt));
                end
            end
            if (req_accept) begin
                if (ahb_addr !== beat_addr(cur, acc_cnt)) begin
                    report_mismatch("ahb_addr", ahb_addr, beat_addr(cur, acc_cnt));
                end
                if (ahb_burst !== t_burst[cur]) begin
                    report_mismatch("ahb_burst", ahb_burst, t_burst[cur]);
                end
                if (ahb_size !== t_size[cur]) begin
                    report_mismatch("ahb_size", ahb_size, t_size[cur]);
                end
                if (ahb_write !== t_write[cur]) begin
                    report_mismatch("ahb_write", ahb_write, t_write[cur]);
                end
                acc_cnt++;
            end
            if (rsp_valid) begin
                rsp_cnt++;
                if (rsp_error) begin
                    err_cnt++;
                end else begin
                    mon_exp = beat_addr(cur, ok_cnt);
                    mon_exp = t_write[cur] ? '0 : ref_mem[mon_exp[9:2]];
                    if (rsp_rdata !== mon_exp) begin
                        report_mismatch("rsp_rdata", rsp_rdata, mon_exp);
                    end
                    ok_cnt++;
                end
            end
        end
    end

    always @(posedge ahb_clk_in) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Run stopped after %0d cycles with the table unfinished", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    task automatic run_row(input int r);
        int beats;
        int delay_left;
        int fails_before;
        beats        = beats_of(t_burst[r]);
        delay_left   = 3;
        fails_before = fail_cnt;
        for (int k = 0; k < 16; k++) begin
            lcg_state   = lcg_next(lcg_state ^ 32'(t_seed[r]));
            row_data[k] = lcg_state;
        end
        @(negedge ahb_clk_in);
        cur        = r;
        row_active = 1'b1;
        req_addr   = t_addr[r];
        req_burst  = t_burst[r];
        req_size   = t_size[r];
        req_write  = t_write[r];
        req_wdata  = row_data[0];
        req_valid  = 1'b1;
        do begin
            @(negedge ahb_clk_in);
            req_wdata = row_data[acc_cnt % 16];
            req_valid = (acc_cnt < beats - 1) && ahb_trans != trans_idle && err_cnt == 0;
            if (ahb_trans == trans_busy) begin
                delay_left--;
            end
            req_delay = t_delay[r] > 0 && delay_left > 0
                        && (acc_cnt == t_delay[r] - 1 || ahb_trans == trans_busy);
        end while (req_valid || busy || dp_active || rsp_cnt == 0);
        req_delay = 1'b0;
        repeat (3) @(negedge ahb_clk_in);

        if (acc_cnt != t_exp_acc[r]) begin
            report_mismatch("accepted beats", acc_cnt, t_exp_acc[r]);
        end
        if (t_exp_err[r] != 0 && err_cnt == 0) begin
            $display("%0t: row %0d finished without the expected error response", $time, r);
            fail_cnt++;
        end
        if (t_exp_err[r] == 0 && err_cnt != 0) begin
            report_mismatch("rsp_error count", err_cnt, 0);
        end
        if (rsp_cnt != t_exp_rsp[r]) begin
            report_mismatch("rsp_valid count", rsp_cnt, t_exp_rsp[r]);
        end
        if (t_exp_acc[r] == 0 && bus_cnt != 0) begin
            report_mismatch("ahb_trans active cycles", bus_cnt, 0);
        end
        if (t_delay[r] > 0 && busy_cnt == 0) begin
            $display("%0t: row %0d never showed a BUSY transfer", $time, r);
            fail_cnt++;
        end
        if (ahb_trans != trans_idle) begin
            report_mismatch("ahb_trans", ahb_trans, trans_idle);
        end
        if (busy !== 1'b0) begin
            report_mismatch("busy", busy, 0);
        end

        if (t_write[r] && t_exp_err[r] == 0) begin
            for (int k = 0; k < beats; k++) begin
                drv_addr = beat_addr(r, k);
                ref_mem[drv_addr[9:2]] = row_data[k];
            end
        end
        if (fail_cnt != fails_before) begin
            rows_failed++;
        end
        $display("row %0d: %s", r, (fail_cnt == fails_before) ? "passed" : "failed");
        row_active = 1'b0;
        repeat (2) @(negedge ahb_clk_in);
    endtask

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i]     = (32'(i) * 32'h0100_0193) ^ 32'h5A5A_C3C3;
            ref_mem[i] = mem[i];
        end
        // addr, burst, size, write, seed, wait, delay beat, error beat,
        // expected error, expected accepted beats, expected responses
        add_row(32'h040, burst_single, 3'd2, 1'b1, 11, 0, 0, -1, 0, 1, 1);
        add_row(32'h040, burst_single, 3'd2, 1'b0, 12, 0, 0, -1, 0, 1, 1);
        add_row(32'h080, burst_incr4,  3'd2, 1'b1, 13, 0, 0, -1, 0, 4, 4);
        add_row(32'h088, burst_wrap4,  3'd2, 1'b0, 14, 1, 0, -1, 0, 4, 4);
        add_row(32'h042, burst_single, 3'd2, 1'b0, 15, 0, 0, -1, 1, 0, 1);
        add_row(32'h100, burst_single, 3'd3, 1'b0, 16, 0, 0, -1, 1, 0, 1);
        add_row(32'h3E0, burst_incr16, 3'd2, 1'b0, 17, 0, 0, -1, 1, 0, 1);
        add_row(32'h060, burst_single, 3'd2, 1'b1, 18, 5, 0, -1, 0, 1, 1);
        add_row(32'h060, burst_single, 3'd2, 1'b0, 19, 6, 0, -1, 1, 1, 1);
        // Two good beats, the erroring beat, then the abort response.
        add_row(32'h0C0, burst_incr8,  3'd2, 1'b0, 20, 0, 0, 2, 1, 3, 4);
        add_row(32'h020, burst_incr4,  3'd2, 1'b1, 21, 0, 1, -1, 0, 4, 4);
        add_row(32'h020, burst_incr4,  3'd2, 1'b0, 22, 0, 0, -1, 0, 4, 4);
        add_row(32'h090, burst_wrap8,  3'd2, 1'b0, 23, 0, 0, -1, 0, 8, 8);

        // Beats times waits per row, with room for setup and BUSY cycles.
        cycle_limit = 50;
        for (int r = 0; r < n_rows; r++) begin
            cycle_limit += beats_of(t_burst[r]) * (t_wait[r] + 1) + 16;
        end

        repeat (3) @(negedge ahb_clk_in);
        ahb_rstn_in = 1'b1;
        @(negedge ahb_clk_in);
        if (ahb_trans !== trans_idle) begin
            report_mismatch("ahb_trans", ahb_trans, trans_idle);
        end
        if (busy !== 1'b0) begin
            report_mismatch("busy", busy, 0);
        end
        if (req_accept !== 1'b0) begin
            report_mismatch("req_accept", req_accept, 0);
        end
        if (rsp_valid !== 1'b0) begin
            report_mismatch("rsp_valid", rsp_valid, 0);
        end
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end

        $display("rows %0d, rows failed %0d, errors %0d", n_rows, rows_failed, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ahb_master_top.sv */
// AHB-Lite master top: request check, FSM, burst address and data phase.
`timescale 1ns/1ps
`default_nettype none

module ahb_master_top #(
    parameter int addr_width   = 32,
    parameter int data_width   = 32,
    parameter int wait_timeout = 6
) (
    input  logic                    ahb_clk_in,
    input  logic                    ahb_rstn_in,
    output logic [addr_width-1:0]   ahb_addr,
    output ahb_bus_pkg::ahb_burst_e ahb_burst,
    output ahb_bus_pkg::ahb_size_t  ahb_size,
    output ahb_bus_pkg::ahb_trans_e ahb_trans,
    output logic                    ahb_write,
    output logic [data_width-1:0]   ahb_wdata,
    input  logic [data_width-1:0]   ahb_rdata,
    input  logic                    ahb_ready,
    input  logic                    ahb_resp,
    input  logic                    req_valid,
    input  logic                    req_write,
    input  logic                    req_delay,
    input  logic [addr_width-1:0]   req_addr,
    input  ahb_bus_pkg::ahb_burst_e req_burst,
    input  ahb_bus_pkg::ahb_size_t  req_size,
    input  logic [data_width-1:0]   req_wdata,
    output logic                    req_accept,
    output logic                    busy,
    output logic                    rsp_valid,
    output logic                    rsp_error,
    output logic [data_width-1:0]   rsp_rdata
);

    logic req_ok;
    logic start_burst;
    logic beat_taken;
    logic busy_hold;
    logic abort;
    logic last_beat;
    logic data_pending;
    logic data_error;

    ahb_req_check #(
        .addr_width(addr_width),
        .data_width(data_width)
    ) u_req_check (
        .req_addr (req_addr),
        .req_burst(req_burst),
        .req_size (req_size),
        .req_ok   (req_ok)
    );

    ahb_master_fsm #(
        .wait_timeout(wait_timeout)
    ) u_fsm (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .req_valid   (req_valid),
        .req_ok      (req_ok),
        .req_delay   (req_delay),
        .req_write   (req_write),
        .last_beat   (last_beat),
        .data_pending(data_pending),
        .data_error  (data_error),
        .ahb_ready   (ahb_ready),
        .ahb_trans   (ahb_trans),
        .ahb_write   (ahb_write),
        .busy        (busy),
        .req_accept  (req_accept),
        .start_burst (start_burst),
        .beat_taken  (beat_taken),
        .busy_hold   (busy_hold),
        .abort       (abort)
    );

    ahb_burst_addr #(
        .addr_width(addr_width)
    ) u_burst_addr (
        .ahb_clk_in (ahb_clk_in),
        .ahb_rstn_in(ahb_rstn_in),
        .start_burst(start_burst),
        .beat_taken (beat_taken),
        .busy_hold  (busy_hold),
        .req_addr   (req_addr),
        .req_burst  (req_burst),
        .req_size   (req_size),
        .ahb_addr   (ahb_addr),
        .ahb_burst  (ahb_burst),
        .ahb_size   (ahb_size),
        .last_beat  (last_beat)
    );

    ahb_data_phase #(
        .data_width(data_width)
    ) u_data_phase (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .beat_taken  (beat_taken),
        .abort       (abort),
        .ahb_write   (ahb_write),
        .ahb_ready   (ahb_ready),
        .ahb_resp    (ahb_resp),
        .req_wdata   (req_wdata),
        .ahb_rdata   (ahb_rdata),
        .ahb_wdata   (ahb_wdata),
        .data_pending(data_pending),
        .data_error  (data_error),
        .rsp_valid   (rsp_valid),
        .rsp_error   (rsp_error),
        .rsp_rdata   (rsp_rdata)
    );

endmodule

`default_nettype wire

/* ahb_data_phase.sv */
// Data-phase tracking, HWDATA drive and the user response.
`timescale 1ns/1ps
`default_nettype none

module ahb_data_phase #(
    parameter int data_width = 32
) (
    input  logic                  ahb_clk_in,
    input  logic                  ahb_rstn_in,
    input  logic                  beat_taken,
    input  logic                  abort,
    input  logic                  ahb_write,
    input  logic                  ahb_ready,
    input  logic                  ahb_resp,
    input  logic [data_width-1:0] req_wdata,
    input  logic [data_width-1:0] ahb_rdata,
    output logic [data_width-1:0] ahb_wdata,
    output logic                  data_pending,
    output logic                  data_error,
    output logic                  rsp_valid,
    output logic                  rsp_error,
    output logic [data_width-1:0] rsp_rdata
);

    logic write_q;

    // Beat payload for the data phase.
    always_ff @(posedge ahb_clk_in) begin
        if (beat_taken) begin
            write_q   <= ahb_write;
            ahb_wdata <= req_wdata;
        end
    end

    ////////////////////////////////////////
    always_ff @(posedge ahb_clk_in) begin
        if (!ahb_rstn_in) begin
            data_pending <= 1'b0;
            rsp_valid    <= 1'b0;
            rsp_error    <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            if (abort) begin
                data_pending <= 1'b0;
                rsp_valid    <= 1'b1;
                rsp_error    <= 1'b1;
                rsp_rdata    <= '0;
            end else begin
                if (data_pending && ahb_ready) begin
                    rsp_valid <= 1'b1;
                    rsp_error <= ahb_resp;
                    rsp_rdata <= write_q ? '0 : ahb_rdata;
                end
                // A new beat can enter as the previous one completes.
                if (beat_taken) begin
                    data_pending <= 1'b1;
                end else if (ahb_ready) begin
                    data_pending <= 1'b0;
                end
            end
        end
    end

    assign data_error = data_pending && ahb_resp;

endmodule

`default_nettype wire

/* ahb_master_fsm.sv */
// Transfer FSM, HTRANS and HWRITE drive, beat strobes and wait-state timeout.
`timescale 1ns/1ps
`default_nettype none

module ahb_master_fsm #(
    parameter int wait_timeout = 6
) (
    input  logic                    ahb_clk_in,
    input  logic                    ahb_rstn_in,
    input  logic                    req_valid,
    input  logic                    req_ok,
    input  logic                    req_delay,
    input  logic                    req_write,
    input  logic                    last_beat,
    input  logic                    data_pending,
    input  logic                    data_error,
    input  logic                    ahb_ready,
    output ahb_bus_pkg::ahb_trans_e ahb_trans,
    output logic                    ahb_write,
    output logic                    busy,
    output logic                    req_accept,
    output logic                    start_burst,
    output logic                    beat_taken,
    output logic                    busy_hold,
    output logic                    abort
);

    import ahb_bus_pkg::*;
    import ahb_master_pkg::*;

    localparam int wait_w = $clog2(wait_timeout + 1);

    master_state_e     state;
    master_state_e     next_state;
    logic [wait_w-1:0] wait_cnt;
    logic              timeout;
    logic              go_error;

    ////////////////////////////////////////
    // Wait-state timer.
    assign timeout  = data_pending && !ahb_ready && (wait_cnt == wait_w'(wait_timeout - 1));
    assign go_error = timeout || data_error;

    always_ff @(posedge ahb_clk_in) begin
        if (!ahb_rstn_in || !data_pending || ahb_ready || state == st_error) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////
    assign beat_taken = (state == st_nonseq || state == st_seq) && ahb_ready && !data_error;
    assign req_accept = beat_taken;

    always_comb begin
        next_state  = state;
        start_burst = 1'b0;
        case (state)
            st_idle: begin
                if (go_error) begin
                    next_state = st_error;
                end else if (req_valid && req_ok) begin
                    next_state  = st_nonseq;
                    start_burst = 1'b1;
                end else if (req_valid && !data_pending) begin
                    next_state = st_error;
                end
            end
            st_nonseq, st_seq: begin
                if (go_error) begin
                    next_state = st_error;
                end else if (beat_taken) begin
                    if (last_beat || !req_valid) begin
                        // Back-to-back request may follow without an idle cycle.
                        if (req_valid && req_ok) begin
                            next_state  = st_nonseq;
                            start_burst = 1'b1;
                        end else begin
                            next_state = st_idle;
                        end
                    end else if (req_delay) begin
                        next_state = st_busy;
                    end else begin
                        next_state = st_seq;
                    end
                end
            end
            st_busy: begin
                if (go_error) begin
                    next_state = st_error;
                end else if (ahb_ready && !req_delay) begin
                    next_state = st_seq;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge ahb_clk_in) begin
        if (!ahb_rstn_in) begin
            state     <= st_idle;
            ahb_write <= 1'b0;
        end else begin
            state <= next_state;
            if (start_burst) begin
                ahb_write <= req_write;
            end
        end
    end

    ////////////////////////////////////////
    always_comb begin
        case (state)
            st_nonseq: ahb_trans = trans_nonseq;
            st_seq:    ahb_trans = trans_seq;
            st_busy:   ahb_trans = trans_busy;
            default:   ahb_trans = trans_idle;
        endcase
    end

    assign busy_hold = (state == st_busy);
    assign abort     = (state == st_error);
    assign busy      = (state != st_idle) || data_pending;

    // BUSY only resumes the running burst.
    a_busy_not_nonseq: assert property (
        @(posedge ahb_clk_in) disable iff (!ahb_rstn_in)
        ahb_trans == trans_busy |=> ahb_trans != trans_nonseq
    );

endmodule

`default_nettype wire

/* ahb_burst_addr.sv */
// Beat counter and next-address generation for incrementing and wrapping bursts.
`timescale 1ns/1ps
`default_nettype none

module ahb_burst_addr #(
    parameter int addr_width = 32
) (
    input  logic                    ahb_clk_in,
    input  logic                    ahb_rstn_in,
    input  logic                    start_burst,
    input  logic                    beat_taken,
    input  logic                    busy_hold,
    input  logic [addr_width-1:0]   req_addr,
    input  ahb_bus_pkg::ahb_burst_e req_burst,
    input  ahb_bus_pkg::ahb_size_t  req_size,
    output logic [addr_width-1:0]   ahb_addr,
    output ahb_bus_pkg::ahb_burst_e ahb_burst,
    output ahb_bus_pkg::ahb_size_t  ahb_size,
    output logic                    last_beat
);

    import ahb_bus_pkg::*;

    logic [3:0]            beat_cnt;
    logic                  advance;
    logic [addr_width-1:0] incr_addr;
    logic [addr_width-1:0] wrap_mask;
    logic [addr_width-1:0] wrap_addr;
    logic [addr_width-1:0] next_addr;

    ////////////////////////////////////////
    // Next beat address.
    assign incr_addr = ahb_addr + (addr_width'(1) << ahb_size);
    assign wrap_mask = (addr_width'(burst_beats(ahb_burst)) << ahb_size) - addr_width'(1);

    // Upper bits stay, lower bits roll over inside the wrap region.
    assign wrap_addr = (ahb_addr & ~wrap_mask) | (incr_addr & wrap_mask);
    assign next_addr = burst_is_wrap(ahb_burst) ? wrap_addr : incr_addr;

    assign advance = beat_taken && !busy_hold;

    ////////////////////////////////////////
    // Address-phase registers.
    always_ff @(posedge ahb_clk_in) begin
        if (!ahb_rstn_in) begin
            ahb_addr  <= '0;
            ahb_burst <= burst_single;
            ahb_size  <= '0;
            beat_cnt  <= '0;
        end else if (start_burst) begin
            ahb_addr  <= req_addr;
            ahb_burst <= req_burst;
            ahb_size  <= req_size;
            beat_cnt  <= 4'(burst_beats(req_burst) - 5'd1);
        end else if (advance) begin
            ahb_addr <= next_addr;
            // INCR has no fixed length.
            if (ahb_burst != burst_incr && beat_cnt != '0) begin
                beat_cnt <= beat_cnt - 4'd1;
            end
        end
    end

    assign last_beat = (beat_cnt == '0) && (ahb_burst != burst_incr);

    // Once the final beat of a fixed burst is taken, the FSM leaves the burst.
    a_no_beat_past_end: assert property (
        @(posedge ahb_clk_in) disable iff (!ahb_rstn_in)
        beat_taken && last_beat && !start_burst |=> !beat_taken
    );

endmodule

`default_nettype wire

/* ahb_req_check.sv */
// Legality check of a new user request: size, alignment, 1 KB crossing.
`timescale 1ns/1ps
`default_nettype none

module ahb_req_check #(
    parameter int addr_width = 32,
    parameter int data_width = 32
) (
    input  logic [addr_width-1:0]  req_addr,
    input  ahb_bus_pkg::ahb_burst_e req_burst,
    input  ahb_bus_pkg::ahb_size_t  req_size,
    output logic                    req_ok
);

    import ahb_bus_pkg::*;
    import ahb_master_pkg::*;

    logic [10:0]           size_bits;
    logic [addr_width-1:0] size_mask;
    logic [addr_width-1:0] burst_span;
    logic [addr_width-1:0] last_addr;
    logic                  size_ok;
    logic                  align_ok;
    logic                  bound_ok;

    ////////////////////////////////////////
    // Size against the data bus.
    assign size_bits = 11'(1) << (4'(req_size) + 4'd3);
    assign size_ok   = int'(size_bits) <= data_width;

    // Address must sit on a beat boundary.
    assign size_mask = (addr_width'(1) << req_size) - addr_width'(1);
    assign align_ok  = (req_addr & size_mask) == '0;

    ////////////////////////////////////////
    // Fixed incrementing bursts stay inside one 1 KB region.
    assign burst_span = addr_width'(burst_beats(req_burst)) << req_size;
    assign last_addr  = req_addr + burst_span - addr_width'(1);

    always_comb begin
        bound_ok = 1'b1;
        if (req_burst inside {burst_incr4, burst_incr8, burst_incr16}) begin
            bound_ok = req_addr[addr_width-1:kb_boundary_bits]
                       == last_addr[addr_width-1:kb_boundary_bits];
        end
    end

    assign req_ok = size_ok && align_ok && bound_ok;

endmodule

`default_nettype wire

/* ahb_master_pkg.sv */
// Master state encoding and the 1 KB boundary position.
`default_nettype none

package ahb_master_pkg;

    // Transfer FSM states.
    typedef enum logic [2:0] {
        st_idle   = 3'd0,
        st_nonseq = 3'd1,
        st_seq    = 3'd2,
        st_busy   = 3'd3,
        st_error  = 3'd4
    } master_state_e;

    // Lowest address bit of a 1 KB region.
    localparam int kb_boundary_bits = 10;

endpackage

`default_nettype wire

/* ahb_bus_pkg.sv */
// AHB-Lite protocol types: burst codes, transfer types, size code.
// Burst helpers for beat count and wrap detection.
`default_nettype none

package ahb_bus_pkg;

    // Burst codes in bus encoding.
    typedef enum logic [2:0] {
        burst_single = 3'd0,
        burst_incr   = 3'd1,
        burst_wrap4  = 3'd2,
        burst_incr4  = 3'd3,
        burst_wrap8  = 3'd4,
        burst_incr8  = 3'd5,
        burst_wrap16 = 3'd6,
        burst_incr16 = 3'd7
    } ahb_burst_e;

    typedef enum logic [1:0] {
        trans_idle   = 2'd0,
        trans_busy   = 2'd1,
        trans_nonseq = 2'd2,
        trans_seq    = 2'd3
    } ahb_trans_e;

    // Bytes per beat is 2**size.
    typedef logic [2:0] ahb_size_t;

    function automatic logic [4:0] burst_beats(input ahb_burst_e burst);
        case (burst)
            burst_wrap4, burst_incr4:   return 5'd4;
            burst_wrap8, burst_incr8:   return 5'd8;
            burst_wrap16, burst_incr16: return 5'd16;
            default:                    return 5'd1;
        endcase
    endfunction

    function automatic logic burst_is_wrap(input ahb_burst_e burst);
        return burst inside {burst_wrap4, burst_wrap8, burst_wrap16};
    endfunction

endpackage

`default_nettype wire
